// ==== verilog/dma_attach_defs.svh ====
// dma attachment shared widths
// stream data, byte enable, pipeline sideband and packet size fields

`ifndef DMA_ATTACH_DEFS_SVH
`define DMA_ATTACH_DEFS_SVH

// stream data bus width in bits
`define DMA_DATA_WIDTH 512

// one keep bit per data byte
`define DMA_KEEP_WIDTH (`DMA_DATA_WIDTH / 8)

// pipeline sideband, holds size, src, dst and a reserved remainder
`define PIPE_TUSER_WIDTH 128

// host byte count carried with each packet
`define DMA_SIZE_WIDTH 16

// width of a one-hot port field in tuser
`define DMA_PORT_WIDTH 8

`endif

// ==== verilog/dma_attach_pkg.sv ====
// dma attachment types
// port numbers, pipeline sideband layout and FSM state encodings
`default_nettype none

`include "dma_attach_defs.svh"

package dma_attach_pkg;

  // one-hot interface numbers as seen by the pipeline
  typedef enum logic [`DMA_PORT_WIDTH-1:0] {
    IF_CMAC0 = 8'h01,
    IF_QDMA0 = 8'h02,
    IF_CMAC1 = 8'h04,
    IF_QDMA1 = 8'h08
  } if_num_e;

  // pipeline tuser, lowest field first from the bottom
  typedef struct packed {
    logic [`PIPE_TUSER_WIDTH-`DMA_SIZE_WIDTH-2*`DMA_PORT_WIDTH-1:0] reserved;
    logic [`DMA_PORT_WIDTH-1:0]                                     dst_port;
    logic [`DMA_PORT_WIDTH-1:0]                                     src_port;
    logic [`DMA_SIZE_WIDTH-1:0]                                     size;
  } pipe_tuser_t;

  typedef enum logic [1:0] {ARB_IDLE, ARB_Q0, ARB_Q1} arb_state_e;

  typedef enum logic {STEER_IDLE, STEER_PKT} steer_state_e;

endpackage

`default_nettype wire

// ==== verilog/pipe_stream_if.sv ====
// pipeline stream interface
// valid/ready packet stream with the pipeline tuser sideband
`timescale 1ns/1ps
`default_nettype none

`include "dma_attach_defs.svh"

interface pipe_stream_if;

  logic [`DMA_DATA_WIDTH-1:0]  tdata;
  logic [`DMA_KEEP_WIDTH-1:0]  tkeep;
  dma_attach_pkg::pipe_tuser_t tuser;
  logic                        tlast;
  logic                        tvalid;
  logic                        tready;

  // beat producer
  modport source (
    output tdata, tkeep, tuser, tlast, tvalid,
    input  tready
  );

  // beat consumer
  modport sink (
    input  tdata, tkeep, tuser, tlast, tvalid,
    output tready
  );

endinterface

`default_nettype wire

// ==== verilog/h2c_arbiter.sv ====
// host-to-card merge
// packet-level round-robin of two host queues onto the pipeline,
// tagging tuser with the queue's interface number and byte count
`timescale 1ns/1ps
`default_nettype none

`include "dma_attach_defs.svh"

module h2c_arbiter (
  input  logic                       axis_aclk,
  input  logic                       axis_rst,

  input  logic [`DMA_DATA_WIDTH-1:0] h2c_0_tdata,
  input  logic [`DMA_KEEP_WIDTH-1:0] h2c_0_tkeep,
  input  logic                       h2c_0_tlast,
  input  logic [`DMA_SIZE_WIDTH-1:0] h2c_0_tsize,
  input  logic                       h2c_0_tvalid,
  output logic                       h2c_0_tready,

  input  logic [`DMA_DATA_WIDTH-1:0] h2c_1_tdata,
  input  logic [`DMA_KEEP_WIDTH-1:0] h2c_1_tkeep,
  input  logic                       h2c_1_tlast,
  input  logic [`DMA_SIZE_WIDTH-1:0] h2c_1_tsize,
  input  logic                       h2c_1_tvalid,
  output logic                       h2c_1_tready,

  pipe_stream_if.source              pipe
);

  dma_attach_pkg::arb_state_e  state;
  dma_attach_pkg::arb_state_e  state_nxt;
  dma_attach_pkg::pipe_tuser_t tuser_c;
  logic                        last_q1;
  logic                        sel_q1;

  // grant choice and release on the tlast transfer
  always_comb begin
    state_nxt = state;
    case (state)
      dma_attach_pkg::ARB_IDLE: begin
        // the queue not served last wins a tie
        if (h2c_0_tvalid && (!h2c_1_tvalid || last_q1)) begin
          state_nxt = dma_attach_pkg::ARB_Q0;
        end else if (h2c_1_tvalid) begin
          state_nxt = dma_attach_pkg::ARB_Q1;
        end
      end
      dma_attach_pkg::ARB_Q0: begin
        if (h2c_0_tvalid && pipe.tready && h2c_0_tlast) begin
          state_nxt = dma_attach_pkg::ARB_IDLE;
        end
      end
      dma_attach_pkg::ARB_Q1: begin
        if (h2c_1_tvalid && pipe.tready && h2c_1_tlast) begin
          state_nxt = dma_attach_pkg::ARB_IDLE;
        end
      end
      default: state_nxt = dma_attach_pkg::ARB_IDLE;
    endcase
  end

  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      state   <= dma_attach_pkg::ARB_IDLE;
      last_q1 <= 1'b1;
    end else begin
      state <= state_nxt;
      // remember who got the grant for the next tie
      if (state == dma_attach_pkg::ARB_IDLE && state_nxt != dma_attach_pkg::ARB_IDLE) begin
        last_q1 <= (state_nxt == dma_attach_pkg::ARB_Q1);
      end
    end
  end

  assign sel_q1 = (state == dma_attach_pkg::ARB_Q1);

  // sideband tag, dst and reserved stay zero
  always_comb begin
    tuser_c          = '0;
    tuser_c.size     = sel_q1 ? h2c_1_tsize : h2c_0_tsize;
    tuser_c.src_port = sel_q1 ? dma_attach_pkg::IF_QDMA1 : dma_attach_pkg::IF_QDMA0;
  end

  // granted queue straight through, no register on the path
  assign pipe.tdata  = sel_q1 ? h2c_1_tdata : h2c_0_tdata;
  assign pipe.tkeep  = sel_q1 ? h2c_1_tkeep : h2c_0_tkeep;
  assign pipe.tlast  = sel_q1 ? h2c_1_tlast : h2c_0_tlast;
  assign pipe.tuser  = tuser_c;
  assign pipe.tvalid = (state == dma_attach_pkg::ARB_Q0 && h2c_0_tvalid) ||
                       (state == dma_attach_pkg::ARB_Q1 && h2c_1_tvalid);

  // back-pressure reaches only the granted queue
  assign h2c_0_tready = (state == dma_attach_pkg::ARB_Q0) && pipe.tready;
  assign h2c_1_tready = (state == dma_attach_pkg::ARB_Q1) && pipe.tready;

endmodule

`default_nettype wire

// ==== verilog/c2h_steering.sv ====
// card-to-host steering
// sends each pipeline packet to c2h 0 and/or c2h 1 by its destination
// mask, holding size and source from the first beat to tlast
`timescale 1ns/1ps
`default_nettype none

`include "dma_attach_defs.svh"

module c2h_steering (
  input  logic                       axis_aclk,
  input  logic                       axis_rst,

  pipe_stream_if.sink                pipe,

  output logic [`DMA_DATA_WIDTH-1:0] c2h_0_tdata,
  output logic [`DMA_KEEP_WIDTH-1:0] c2h_0_tkeep,
  output logic                       c2h_0_tlast,
  output logic [`DMA_SIZE_WIDTH-1:0] c2h_0_tsize,
  output logic [`DMA_PORT_WIDTH-1:0] c2h_0_tsrc,
  output logic                       c2h_0_tvalid,
  input  logic                       c2h_0_tready,

  output logic [`DMA_DATA_WIDTH-1:0] c2h_1_tdata,
  output logic [`DMA_KEEP_WIDTH-1:0] c2h_1_tkeep,
  output logic                       c2h_1_tlast,
  output logic [`DMA_SIZE_WIDTH-1:0] c2h_1_tsize,
  output logic [`DMA_PORT_WIDTH-1:0] c2h_1_tsrc,
  output logic                       c2h_1_tvalid,
  input  logic                       c2h_1_tready
);

  dma_attach_pkg::steer_state_e state;
  logic [`DMA_PORT_WIDTH-1:0]   dst_hold;
  logic [`DMA_SIZE_WIDTH-1:0]   size_hold;
  logic [`DMA_PORT_WIDTH-1:0]   src_hold;
  logic                         first_beat;
  logic [`DMA_PORT_WIDTH-1:0]   cur_dst;
  logic [`DMA_SIZE_WIDTH-1:0]   cur_size;
  logic [`DMA_PORT_WIDTH-1:0]   cur_src;
  logic                         sel_0;
  logic                         sel_1;
  logic                         xfer;

  assign first_beat = (state == dma_attach_pkg::STEER_IDLE);
  assign xfer       = pipe.tvalid && pipe.tready;

  // live fields on the first beat, held copies afterwards
  assign cur_dst  = first_beat ? pipe.tuser.dst_port : dst_hold;
  assign cur_size = first_beat ? pipe.tuser.size     : size_hold;
  assign cur_src  = first_beat ? pipe.tuser.src_port : src_hold;

  assign sel_0 = |(cur_dst & dma_attach_pkg::IF_QDMA0);
  assign sel_1 = |(cur_dst & dma_attach_pkg::IF_QDMA1);

  always_ff @(posedge axis_aclk) begin
    if (axis_rst) begin
      state <= dma_attach_pkg::STEER_IDLE;
    end else if (xfer) begin
      state <= pipe.tlast ? dma_attach_pkg::STEER_IDLE : dma_attach_pkg::STEER_PKT;
    end
  end

  // packet metadata, captured on the first transfer
  always_ff @(posedge axis_aclk) begin
    if (xfer && first_beat) begin
      dst_hold  <= pipe.tuser.dst_port;
      size_hold <= pipe.tuser.size;
      src_hold  <= pipe.tuser.src_port;
    end
  end

  // a broadcast beat waits for both queues so each gets it exactly once
  assign pipe.tready = (!sel_0 || c2h_0_tready) && (!sel_1 || c2h_1_tready);

  // unselected mask falls through here and the beat is dropped
  assign c2h_0_tvalid = pipe.tvalid && sel_0 && (!sel_1 || c2h_1_tready);
  assign c2h_1_tvalid = pipe.tvalid && sel_1 && (!sel_0 || c2h_0_tready);

  assign c2h_0_tdata = pipe.tdata;
  assign c2h_0_tkeep = pipe.tkeep;
  assign c2h_0_tlast = pipe.tlast;
  assign c2h_0_tsize = cur_size;
  assign c2h_0_tsrc  = cur_src;

  assign c2h_1_tdata = pipe.tdata;
  assign c2h_1_tkeep = pipe.tkeep;
  assign c2h_1_tlast = pipe.tlast;
  assign c2h_1_tsize = cur_size;
  assign c2h_1_tsrc  = cur_src;

endmodule

`default_nettype wire

// ==== verilog/dma_attachment.sv ====
// dma attachment top level
// host queue merge towards the pipeline and steering back to the host
`timescale 1ns/1ps
`default_nettype none

`include "dma_attach_defs.svh"

module dma_attachment (
  input  logic                        axis_aclk,
  input  logic                        axis_rst,

  // host-to-card queues
  input  logic [`DMA_DATA_WIDTH-1:0]  h2c_0_tdata,
  input  logic [`DMA_KEEP_WIDTH-1:0]  h2c_0_tkeep,
  input  logic                        h2c_0_tlast,
  input  logic [`DMA_SIZE_WIDTH-1:0]  h2c_0_tsize,
  input  logic                        h2c_0_tvalid,
  output logic                        h2c_0_tready,
  input  logic [`DMA_DATA_WIDTH-1:0]  h2c_1_tdata,
  input  logic [`DMA_KEEP_WIDTH-1:0]  h2c_1_tkeep,
  input  logic                        h2c_1_tlast,
  input  logic [`DMA_SIZE_WIDTH-1:0]  h2c_1_tsize,
  input  logic                        h2c_1_tvalid,
  output logic                        h2c_1_tready,

  // card-to-host queues
  output logic [`DMA_DATA_WIDTH-1:0]  c2h_0_tdata,
  output logic [`DMA_KEEP_WIDTH-1:0]  c2h_0_tkeep,
  output logic                        c2h_0_tlast,
  output logic [`DMA_SIZE_WIDTH-1:0]  c2h_0_tsize,
  output logic [`DMA_PORT_WIDTH-1:0]  c2h_0_tsrc,
  output logic                        c2h_0_tvalid,
  input  logic                        c2h_0_tready,
  output logic [`DMA_DATA_WIDTH-1:0]  c2h_1_tdata,
  output logic [`DMA_KEEP_WIDTH-1:0]  c2h_1_tkeep,
  output logic                        c2h_1_tlast,
  output logic [`DMA_SIZE_WIDTH-1:0]  c2h_1_tsize,
  output logic [`DMA_PORT_WIDTH-1:0]  c2h_1_tsrc,
  output logic                        c2h_1_tvalid,
  input  logic                        c2h_1_tready,

  // merged stream into the pipeline
  output logic [`DMA_DATA_WIDTH-1:0]  pipe_out_tdata,
  output logic [`DMA_KEEP_WIDTH-1:0]  pipe_out_tkeep,
  output logic [`PIPE_TUSER_WIDTH-1:0] pipe_out_tuser,
  output logic                        pipe_out_tlast,
  output logic                        pipe_out_tvalid,
  input  logic                        pipe_out_tready,

  // pipeline stream heading to the host
  input  logic [`DMA_DATA_WIDTH-1:0]  pipe_in_tdata,
  input  logic [`DMA_KEEP_WIDTH-1:0]  pipe_in_tkeep,
  input  logic [`PIPE_TUSER_WIDTH-1:0] pipe_in_tuser,
  input  logic                        pipe_in_tlast,
  input  logic                        pipe_in_tvalid,
  output logic                        pipe_in_tready
);

  pipe_stream_if h2c_pipe ();
  pipe_stream_if c2h_pipe ();

  assign pipe_out_tdata   = h2c_pipe.tdata;
  assign pipe_out_tkeep   = h2c_pipe.tkeep;
  assign pipe_out_tuser   = h2c_pipe.tuser;
  assign pipe_out_tlast   = h2c_pipe.tlast;
  assign pipe_out_tvalid  = h2c_pipe.tvalid;
  assign h2c_pipe.tready  = pipe_out_tready;

  assign c2h_pipe.tdata   = pipe_in_tdata;
  assign c2h_pipe.tkeep   = pipe_in_tkeep;
  assign c2h_pipe.tuser   = pipe_in_tuser;
  assign c2h_pipe.tlast   = pipe_in_tlast;
  assign c2h_pipe.tvalid  = pipe_in_tvalid;
  assign pipe_in_tready   = c2h_pipe.tready;

  h2c_arbiter u_h2c_arbiter (
    .axis_aclk    (axis_aclk),
    .axis_rst     (axis_rst),
    .h2c_0_tdata  (h2c_0_tdata),
    .h2c_0_tkeep  (h2c_0_tkeep),
    .h2c_0_tlast  (h2c_0_tlast),
    .h2c_0_tsize  (h2c_0_tsize),
    .h2c_0_tvalid (h2c_0_tvalid),
    .h2c_0_tready (h2c_0_tready),
    .h2c_1_tdata  (h2c_1_tdata),
    .h2c_1_tkeep  (h2c_1_tkeep),
    .h2c_1_tlast  (h2c_1_tlast),
    .h2c_1_tsize  (h2c_1_tsize),
    .h2c_1_tvalid (h2c_1_tvalid),
    .h2c_1_tready (h2c_1_tready),
    .pipe         (h2c_pipe.source)
  );

  c2h_steering u_c2h_steering (
    .axis_aclk    (axis_aclk),
    .axis_rst     (axis_rst),
    .pipe         (c2h_pipe.sink),
    .c2h_0_tdata  (c2h_0_tdata),
    .c2h_0_tkeep  (c2h_0_tkeep),
    .c2h_0_tlast  (c2h_0_tlast),
    .c2h_0_tsize  (c2h_0_tsize),
    .c2h_0_tsrc   (c2h_0_tsrc),
    .c2h_0_tvalid (c2h_0_tvalid),
    .c2h_0_tready (c2h_0_tready),
    .c2h_1_tdata  (c2h_1_tdata),
    .c2h_1_tkeep  (c2h_1_tkeep),
    .c2h_1_tlast  (c2h_1_tlast),
    .c2h_1_tsize  (c2h_1_tsize),
    .c2h_1_tsrc   (c2h_1_tsrc),
    .c2h_1_tvalid (c2h_1_tvalid),
    .c2h_1_tready (c2h_1_tready)
  );

endmodule

`default_nettype wire

// ==== bench/tb_dma_attachment.sv ====
// dma attachment testbench
// random packets through the h2c merge and the c2h steering,
// checked beat by beat against per-queue expected streams
`timescale 1ns/1ps
`default_nettype none

`include "dma_attach_defs.svh"

module tb_dma_attachment;

  // packets over all tests, at most four beats each
  localparam int N_PKTS   = 2 + 16 + 20 + 4 + 12;
  localparam int N_CYCLES = 20 * N_PKTS * 4 + 200;

  typedef struct packed {
    logic [`DMA_DATA_WIDTH-1:0]  data;
    logic [`DMA_KEEP_WIDTH-1:0]  keep;
    logic                        last;
    dma_attach_pkg::pipe_tuser_t tuser;
    logic [`DMA_PORT_WIDTH-1:0]  dst;
  } beat_t;

  logic                         axis_aclk;
  logic                         axis_rst;
  logic [`DMA_DATA_WIDTH-1:0]   h2c_0_tdata;
  logic [`DMA_KEEP_WIDTH-1:0]   h2c_0_tkeep;
  logic                         h2c_0_tlast;
  logic [`DMA_SIZE_WIDTH-1:0]   h2c_0_tsize;
  logic                         h2c_0_tvalid;
  logic                         h2c_0_tready;
  logic [`DMA_DATA_WIDTH-1:0]   h2c_1_tdata;
  logic [`DMA_KEEP_WIDTH-1:0]   h2c_1_tkeep;
  logic                         h2c_1_tlast;
  logic [`DMA_SIZE_WIDTH-1:0]   h2c_1_tsize;
  logic                         h2c_1_tvalid;
  logic                         h2c_1_tready;
  logic [`DMA_DATA_WIDTH-1:0]   c2h_0_tdata;
  logic [`DMA_KEEP_WIDTH-1:0]   c2h_0_tkeep;
  logic                         c2h_0_tlast;
  logic [`DMA_SIZE_WIDTH-1:0]   c2h_0_tsize;
  logic [`DMA_PORT_WIDTH-1:0]   c2h_0_tsrc;
  logic                         c2h_0_tvalid;
  logic                         c2h_0_tready;
  logic [`DMA_DATA_WIDTH-1:0]   c2h_1_tdata;
  logic [`DMA_KEEP_WIDTH-1:0]   c2h_1_tkeep;
  logic                         c2h_1_tlast;
  logic [`DMA_SIZE_WIDTH-1:0]   c2h_1_tsize;
  logic [`DMA_PORT_WIDTH-1:0]   c2h_1_tsrc;
  logic                         c2h_1_tvalid;
  logic                         c2h_1_tready;
  logic [`DMA_DATA_WIDTH-1:0]   pipe_out_tdata;
  logic [`DMA_KEEP_WIDTH-1:0]   pipe_out_tkeep;
  logic [`PIPE_TUSER_WIDTH-1:0] pipe_out_tuser;
  logic                         pipe_out_tlast;
  logic                         pipe_out_tvalid;
  logic                         pipe_out_tready;
  logic [`DMA_DATA_WIDTH-1:0]   pipe_in_tdata;
  logic [`DMA_KEEP_WIDTH-1:0]   pipe_in_tkeep;
  logic [`PIPE_TUSER_WIDTH-1:0] pipe_in_tuser;
  logic                         pipe_in_tlast;
  logic                         pipe_in_tvalid;
  logic                         pipe_in_tready;

  // stimulus queues and expected output streams
  beat_t send_h0[$];
  beat_t send_h1[$];
  beat_t send_in[$];
  beat_t exp_h0[$];
  beat_t exp_h1[$];
  beat_t exp_c0[$];
  beat_t exp_c1[$];
  beat_t head;
  beat_t exp_beat;

  logic [31:0]                 lcg_state = 32'hb687_04e0;
  logic [31:0]                 stall_bits;
  logic                        stall_en = 1'b0;
  logic                        fair_chk = 1'b0;
  logic [`DMA_PORT_WIDTH-1:0]  in_dst = '0;
  dma_attach_pkg::pipe_tuser_t out_user;
  logic                        out_in_pkt = 1'b0;
  logic                        out_stalled = 1'b0;
  logic                        have_last = 1'b0;
  logic [`DMA_PORT_WIDTH-1:0]  cur_src;
  logic [`DMA_PORT_WIDTH-1:0]  last_src;
  logic [`DMA_DATA_WIDTH-1:0]  prev_data;
  logic [`DMA_KEEP_WIDTH-1:0]  prev_keep;
  logic [`PIPE_TUSER_WIDTH-1:0] prev_user;
  logic                        prev_last;
  int                          pkt_cnt0 = 0;
  int                          pkt_cnt1 = 0;
  int                          base0;
  int                          base1;
  int                          cnt_diff;
  int                          pick;
  int                          errors = 0;
  string                       test_name = "reset";

  dma_attachment u_dma_attachment (.*);

  always #5 axis_aclk = ~axis_aclk;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [`DMA_DATA_WIDTH-1:0] random_data();
    logic [`DMA_DATA_WIDTH-1:0] d;
    for (int i = 0; i < `DMA_DATA_WIDTH / 32; i++) begin
      d[i*32 +: 32] = next_random();
    end
    return d;
  endfunction

  task automatic check_value(input string what, input logic [`DMA_DATA_WIDTH-1:0] exp_v,
                             input logic [`DMA_DATA_WIDTH-1:0] act_v);
    assert (exp_v === act_v) else begin
      errors++;
      $display("[FAIL] %s %s expected %0h actual %0h", test_name, what, exp_v, act_v);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("ERROR in %s: %s", test_name, msg);
  endtask

  // one host packet, expected on pipe_out unchanged and tagged with its queue
  task automatic add_h2c_pkt(input int q);
    beat_t b;
    int    len;
    logic [`DMA_SIZE_WIDTH-1:0] size;
    len  = next_random() % 4 + 1;
    size = next_random();
    for (int i = 0; i < len; i++) begin
      b                = '0;
      b.data           = random_data();
      b.last           = (i == len - 1);
      b.keep           = b.last ? {next_random(), next_random()} : '1;
      b.tuser.size     = size;
      b.tuser.src_port = (q == 1) ? dma_attach_pkg::IF_QDMA1 : dma_attach_pkg::IF_QDMA0;
      if (q == 1) begin
        send_h1.push_back(b);
        exp_h1.push_back(b);
      end else begin
        send_h0.push_back(b);
        exp_h0.push_back(b);
      end
    end
  endtask

  // later beats carry random tuser, the queues must keep the first beat's
  task automatic add_c2h_pkt(input logic [`DMA_PORT_WIDTH-1:0] dst);
    beat_t b;
    beat_t first;
    beat_t e;
    int    len;
    len = next_random() % 4 + 1;
    for (int i = 0; i < len; i++) begin
      b       = '0;
      b.data  = random_data();
      b.keep  = {next_random(), next_random()};
      b.last  = (i == len - 1);
      b.tuser = {next_random(), next_random(), next_random(), next_random()};
      b.dst   = dst;
      if (i == 0) begin
        b.tuser.dst_port = dst;
        first = b;
      end
      send_in.push_back(b);
      e                = b;
      e.tuser.size     = first.tuser.size;
      e.tuser.src_port = first.tuser.src_port;
      if ((dst & dma_attach_pkg::IF_QDMA0) != 0)
        exp_c0.push_back(e);
      if ((dst & dma_attach_pkg::IF_QDMA1) != 0)
        exp_c1.push_back(e);
    end
  endtask

  task automatic wait_drained();
    while (send_h0.size() != 0 || send_h1.size() != 0 || send_in.size() != 0 ||
           exp_h0.size() != 0 || exp_h1.size() != 0 || exp_c0.size() != 0 ||
           exp_c1.size() != 0) begin
      @(posedge axis_aclk);
    end
    repeat (2) @(posedge axis_aclk);
  endtask

  // present the head of each send queue, pop it once it is accepted
  always @(posedge axis_aclk) begin
    stall_bits = next_random();
    pipe_out_tready <= !stall_en || (stall_bits[1:0] != 2'b00);
    c2h_0_tready    <= !stall_en || (stall_bits[3:2] != 2'b00);
    c2h_1_tready    <= !stall_en || (stall_bits[5:4] != 2'b00);
    if (!axis_rst) begin
      if (h2c_0_tvalid && h2c_0_tready)
        void'(send_h0.pop_front());
      if (h2c_1_tvalid && h2c_1_tready)
        void'(send_h1.pop_front());
      if (pipe_in_tvalid && pipe_in_tready)
        void'(send_in.pop_front());
      h2c_0_tvalid   <= (send_h0.size() != 0);
      h2c_1_tvalid   <= (send_h1.size() != 0);
      pipe_in_tvalid <= (send_in.size() != 0);
      if (send_h0.size() != 0) begin
        head = send_h0[0];
        h2c_0_tdata <= head.data;
        h2c_0_tkeep <= head.keep;
        h2c_0_tlast <= head.last;
        h2c_0_tsize <= head.tuser.size;
      end
      if (send_h1.size() != 0) begin
        head = send_h1[0];
        h2c_1_tdata <= head.data;
        h2c_1_tkeep <= head.keep;
        h2c_1_tlast <= head.last;
        h2c_1_tsize <= head.tuser.size;
      end
      if (send_in.size() != 0) begin
        head = send_in[0];
        pipe_in_tdata <= head.data;
        pipe_in_tkeep <= head.keep;
        pipe_in_tlast <= head.last;
        pipe_in_tuser <= head.tuser;
        in_dst        <= head.dst;
      end
    end
  end

  // output monitors, all sampled at the rising edge
  always @(posedge axis_aclk) begin
    if (!axis_rst) begin
      if (out_stalled) begin
        assert (pipe_out_tvalid && pipe_out_tdata == prev_data && pipe_out_tkeep == prev_keep &&
                pipe_out_tuser == prev_user && pipe_out_tlast == prev_last)
          else report_error("pipe_out beat changed while stalled");
      end
      if (pipe_out_tvalid && pipe_out_tready) begin
        out_user = pipe_out_tuser;
        if (out_in_pkt) begin
          assert (out_user.src_port == cur_src) else report_error("packets interleaved on pipe_out");
        end else if (fair_chk && have_last) begin
          assert (out_user.src_port != last_src)
            else report_error("same host queue served twice in a row");
        end
        cur_src    = out_user.src_port;
        out_in_pkt = !pipe_out_tlast;
        if (out_user.src_port == dma_attach_pkg::IF_QDMA0 && exp_h0.size() != 0) begin
          exp_beat = exp_h0.pop_front();
        end else if (out_user.src_port == dma_attach_pkg::IF_QDMA1 && exp_h1.size() != 0) begin
          exp_beat = exp_h1.pop_front();
        end else begin
          report_error("pipe_out beat matches no pending host packet");
          exp_beat = '0;
        end
        check_value("pipe_out_tdata", exp_beat.data, pipe_out_tdata);
        check_value("pipe_out_tkeep", exp_beat.keep, pipe_out_tkeep);
        check_value("pipe_out_tlast", exp_beat.last, pipe_out_tlast);
        check_value("pipe_out_tuser", exp_beat.tuser, pipe_out_tuser);
        if (pipe_out_tlast) begin
          have_last = 1'b1;
          last_src  = out_user.src_port;
          if (out_user.src_port == dma_attach_pkg::IF_QDMA0)
            pkt_cnt0++;
          else
            pkt_cnt1++;
          // running balance while both queues are loaded
          if (fair_chk) begin
            cnt_diff = (pkt_cnt0 - base0) - (pkt_cnt1 - base1);
            assert (cnt_diff >= -1 && cnt_diff <= 1)
              else report_error("packet counts per host queue differ by more than one");
          end
        end
      end
      out_stalled = pipe_out_tvalid && !pipe_out_tready;
      prev_data   = pipe_out_tdata;
      prev_keep   = pipe_out_tkeep;
      prev_user   = pipe_out_tuser;
      prev_last   = pipe_out_tlast;

      // pipeline ready follows every selected host queue
      if (pipe_in_tvalid) begin
        assert (pipe_in_tready ==
                (((in_dst & dma_attach_pkg::IF_QDMA0) == 0 || c2h_0_tready) &&
                 ((in_dst & dma_attach_pkg::IF_QDMA1) == 0 || c2h_1_tready)))
          else report_error("pipe_in_tready does not follow the selected queues");
      end
      if (c2h_0_tvalid && c2h_0_tready) begin
        assert (exp_c0.size() != 0) else report_error("unexpected beat on c2h_0");
        if (exp_c0.size() != 0) begin
          exp_beat = exp_c0.pop_front();
          check_value("c2h_0_tdata", exp_beat.data, c2h_0_tdata);
          check_value("c2h_0_tkeep", exp_beat.keep, c2h_0_tkeep);
          check_value("c2h_0_tlast", exp_beat.last, c2h_0_tlast);
          check_value("c2h_0_tsize", exp_beat.tuser.size, c2h_0_tsize);
          check_value("c2h_0_tsrc", exp_beat.tuser.src_port, c2h_0_tsrc);
        end
      end
      if (c2h_1_tvalid && c2h_1_tready) begin
        assert (exp_c1.size() != 0) else report_error("unexpected beat on c2h_1");
        if (exp_c1.size() != 0) begin
          exp_beat = exp_c1.pop_front();
          check_value("c2h_1_tdata", exp_beat.data, c2h_1_tdata);
          check_value("c2h_1_tkeep", exp_beat.keep, c2h_1_tkeep);
          check_value("c2h_1_tlast", exp_beat.last, c2h_1_tlast);
          check_value("c2h_1_tsize", exp_beat.tuser.size, c2h_1_tsize);
          check_value("c2h_1_tsrc", exp_beat.tuser.src_port, c2h_1_tsrc);
        end
      end
    end
  end

  // run limit scales with the worst case stimulus length
  initial begin
    repeat (N_CYCLES + 10) @(posedge axis_aclk);
    $display("watchdog expired after %0d cycles with stimulus still pending", N_CYCLES);
    $display("errors: %0d", errors + 1);
    $display("tests failed");
    $finish;
  end

  initial begin
    axis_aclk       = 1'b0;
    axis_rst        = 1'b1;
    h2c_0_tdata     = '0;
    h2c_0_tkeep     = '0;
    h2c_0_tlast     = 1'b0;
    h2c_0_tsize     = '0;
    h2c_0_tvalid    = 1'b0;
    h2c_1_tdata     = '0;
    h2c_1_tkeep     = '0;
    h2c_1_tlast     = 1'b0;
    h2c_1_tsize     = '0;
    h2c_1_tvalid    = 1'b0;
    c2h_0_tready    = 1'b1;
    c2h_1_tready    = 1'b1;
    pipe_out_tready = 1'b1;
    pipe_in_tdata   = '0;
    pipe_in_tkeep   = '0;
    pipe_in_tuser   = '0;
    pipe_in_tlast   = 1'b0;
    pipe_in_tvalid  = 1'b0;
    repeat (10) @(posedge axis_aclk);
    axis_rst <= 1'b0;

    test_name = "idle_after_reset";
    repeat (3) begin
      @(posedge axis_aclk);
      check_value("pipe_out_tvalid", 0, pipe_out_tvalid);
      check_value("c2h_0_tvalid", 0, c2h_0_tvalid);
      check_value("c2h_1_tvalid", 0, c2h_1_tvalid);
      check_value("h2c_0_tready", 0, h2c_0_tready);
      check_value("h2c_1_tready", 0, h2c_1_tready);
    end

    test_name = "merge_tagging";
    add_h2c_pkt(0);
    wait_drained();
    add_h2c_pkt(1);
    wait_drained();

    // both queues loaded in the same step so they stay valid together
    test_name = "fair_merge";
    fair_chk  = 1'b1;
    base0     = pkt_cnt0;
    base1     = pkt_cnt1;
    for (int i = 0; i < 8; i++) begin
      add_h2c_pkt(0);
      add_h2c_pkt(1);
    end
    wait_drained();
    fair_chk = 1'b0;

    test_name = "merge_backpressure";
    stall_en  = 1'b1;
    for (int i = 0; i < 20; i++) begin
      add_h2c_pkt(next_random() % 2);
    end
    wait_drained();
    stall_en = 1'b0;

    test_name = "steering";
    add_c2h_pkt(dma_attach_pkg::IF_QDMA0);
    add_c2h_pkt(dma_attach_pkg::IF_QDMA1);
    add_c2h_pkt(dma_attach_pkg::IF_QDMA0 | dma_attach_pkg::IF_QDMA1);
    add_c2h_pkt(dma_attach_pkg::IF_CMAC0);
    wait_drained();

    test_name = "broadcast_backpressure";
    stall_en  = 1'b1;
    for (int i = 0; i < 12; i++) begin
      pick = next_random() % 4;
      if (pick == 0)
        add_c2h_pkt(dma_attach_pkg::IF_QDMA0);
      else if (pick == 1)
        add_c2h_pkt(dma_attach_pkg::IF_QDMA1);
      else
        add_c2h_pkt(dma_attach_pkg::IF_QDMA0 | dma_attach_pkg::IF_QDMA1);
    end
    wait_drained();

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verilog
verilog/dma_attach_pkg.sv
verilog/pipe_stream_if.sv
verilog/h2c_arbiter.sv
verilog/c2h_steering.sv
verilog/dma_attachment.sv
bench/tb_dma_attachment.sv

// ==== Bender.yml ====
package:
  name: dma_attachment

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dma_attach_pkg.sv
      - verilog/pipe_stream_if.sv
      - verilog/h2c_arbiter.sv
      - verilog/c2h_steering.sv
      - verilog/dma_attachment.sv
      - target: simulation
        files:
          - bench/tb_dma_attachment.sv
